/* dsp_defines.svh */
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// one signed q1.15 sample, DAC and ADC side
`define SAMPLE_W 16

// raw table or buffer word, two samples side by side
`define IQ_W (2*`SAMPLE_W)

// envelope tables, all read at one shared address
`define ENV_AW 8

// frequency tables
`define FREQ_AW 4

// acquisition buffer, 64 words
`define ACQ_AW 6

// readout-drive elements summed onto dac_rdrv
`define RDRV_ELEMS 2

`endif

/* dsp_pkg.sv */
`default_nettype none

`include "dsp_defines.svh"

package dsp_pkg;

	// one DAC or ADC sample, q1.15
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// re in the upper half, im in the lower
	typedef struct packed {
		sample_t re;
		sample_t im;
	} iq_s;

	// freq words read as cos/sin, envelope words as x/y
	typedef union packed {
		logic [`IQ_W-1:0] raw;
		iq_s iq;
	} iq_word_u;

	typedef logic [`ENV_AW-1:0] env_addr_t;
	typedef logic [`FREQ_AW-1:0] freq_addr_t;
	typedef logic [`ACQ_AW-1:0] acq_addr_t;

endpackage

`default_nettype wire

/* table_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module table_addr_gen (
	input wire dspif,
	input wire arst_n,
	input wire dsp_pkg::freq_addr_t qdrv_freq_sel,
	input wire dsp_pkg::freq_addr_t rdrv_freq_sel [`RDRV_ELEMS],
	output dsp_pkg::env_addr_t env_addr,
	output dsp_pkg::freq_addr_t qdrv_freq_addr,
	output dsp_pkg::freq_addr_t rdrv_freq_addr [`RDRV_ELEMS]
);
	import dsp_pkg::*;

	freq_addr_t qdrv_sel_q;
	freq_addr_t rdrv_sel_q [`RDRV_ELEMS];

	// envelope address free-runs and wraps
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			env_addr <= '0;
		end else begin
			env_addr <= env_addr + 1'b1;
		end
	end

	// two stages on the selects, same as the host register path
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			qdrv_sel_q <= '0;
			qdrv_freq_addr <= '0;
			for (int i = 0; i < `RDRV_ELEMS; i++) begin
				rdrv_sel_q[i] <= '0;
				rdrv_freq_addr[i] <= '0;
			end
		end else begin
			qdrv_sel_q <= qdrv_freq_sel;
			qdrv_freq_addr <= qdrv_sel_q;
			for (int i = 0; i < `RDRV_ELEMS; i++) begin
				rdrv_sel_q[i] <= rdrv_freq_sel[i];
				rdrv_freq_addr[i] <= rdrv_sel_q[i];
			end
		end
	end

	a_env_step: assert property (@(posedge dspif) disable iff (!arst_n)
		$past(arst_n) |-> env_addr == env_addr_t'($past(env_addr) + 1'b1));

endmodule

`default_nettype wire

/* acq_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module acq_capture (
	input wire dspif,
	input wire arst_n,
	input wire acq_restart,
	input wire dsp_pkg::sample_t adc,
	input wire dsp_pkg::sample_t loopback,
	output dsp_pkg::acq_addr_t acq_addr,
	output logic acq_we,
	output dsp_pkg::iq_word_u acq_data
);
	import dsp_pkg::*;

	logic [1:0] restart_d;
	logic clr;
	sample_t adc_d;

	assign clr = restart_d[1]; // strobe two edges late

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			restart_d <= '0;
		end else begin
			restart_d <= {restart_d[0], acq_restart};
		end
	end

	// fill from 0, write the last word once, then lock
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			acq_addr <= '0;
			acq_we <= 1'b0;
		end else if (clr) begin
			acq_addr <= '0;
			acq_we <= 1'b1;
		end else if (acq_we) begin
			if (&acq_addr) begin
				acq_we <= 1'b0; // locked at all-ones
			end else begin
				acq_addr <= acq_addr + 1'b1;
			end
		end
	end

	// adc two cycles back in re, loopback one cycle back in im
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			adc_d <= '0;
			acq_data.raw <= '0;
		end else begin
			adc_d <= adc;
			acq_data.raw <= {adc_d, loopback};
		end
	end

	a_we_low_on_hold: assert property (@(posedge dspif) disable iff (!arst_n)
		$stable(acq_addr) && $past($stable(acq_addr)) && !$past(clr) |-> !acq_we);

	// only a restart may leave all-ones
	a_no_wrap: assert property (@(posedge dspif) disable iff (!arst_n)
		&$past(acq_addr) && !$past(clr) |-> &acq_addr);

endmodule

`default_nettype wire

/* element_calc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module element_calc (
	input wire dspif,
	input wire arst_n,
	input wire dsp_pkg::iq_word_u freq,
	input wire dsp_pkg::iq_word_u env,
	input wire dsp_pkg::sample_t amp,
	output dsp_pkg::sample_t x,
	output dsp_pkg::sample_t y
);
	import dsp_pkg::*;

	localparam int FRAC = `SAMPLE_W - 1; // q1.15 fraction bits

	iq_word_u freq_q;
	iq_word_u env_q;
	sample_t amp_d1;
	sample_t amp_d2;
	sample_t p_re;
	sample_t p_im;

	logic signed [`IQ_W-1:0] pp_cx;
	logic signed [`IQ_W-1:0] pp_sy;
	logic signed [`IQ_W-1:0] pp_cy;
	logic signed [`IQ_W-1:0] pp_sx;
	logic signed [`IQ_W-1:0] sc_re;
	logic signed [`IQ_W-1:0] sc_im;

	// stage 1, input registers
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			freq_q <= '0;
			env_q <= '0;
			amp_d1 <= '0;
		end else begin
			freq_q <= freq;
			env_q <= env;
			amp_d1 <= amp;
		end
	end

	// cos/sin from the freq word, x/y from the envelope word
	always_comb begin
		pp_cx = freq_q.iq.re * env_q.iq.re;
		pp_sy = freq_q.iq.im * env_q.iq.im;
		pp_cy = freq_q.iq.re * env_q.iq.im;
		pp_sx = freq_q.iq.im * env_q.iq.re;
	end

	// stage 2, (cos + j sin)(x + j y), each term >>15 then wrap
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			p_re <= '0;
			p_im <= '0;
			amp_d2 <= '0;
		end else begin
			p_re <= pp_cx[FRAC +: `SAMPLE_W] - pp_sy[FRAC +: `SAMPLE_W];
			p_im <= pp_cy[FRAC +: `SAMPLE_W] + pp_sx[FRAC +: `SAMPLE_W];
			amp_d2 <= amp_d1;
		end
	end

	always_comb begin
		sc_re = p_re * amp_d2;
		sc_im = p_im * amp_d2;
	end

	// stage 3, amplitude scaling
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			x <= '0;
			y <= '0;
		end else begin
			x <= sc_re[FRAC +: `SAMPLE_W]; // truncated
			y <= sc_im[FRAC +: `SAMPLE_W];
		end
	end

endmodule

`default_nettype wire

/* dac_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module dac_combiner (
	input wire dspif,
	input wire arst_n,
	input wire dsp_pkg::sample_t qdrv_x,
	input wire dsp_pkg::sample_t rdrv_x [`RDRV_ELEMS],
	output dsp_pkg::sample_t dac_qdrv,
	output dsp_pkg::sample_t dac_rdrv
);
	import dsp_pkg::*;

	sample_t rdrv_acc;
	sample_t rdrv_sum;
	sample_t qdrv_d;

	// plain 16-bit adds, overflow wraps
	always_comb begin
		rdrv_acc = '0;
		for (int i = 0; i < `RDRV_ELEMS; i++) begin
			rdrv_acc = rdrv_acc + rdrv_x[i];
		end
	end

	// tree register, qdrv delayed alongside
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			rdrv_sum <= '0;
			qdrv_d <= '0;
		end else begin
			rdrv_sum <= rdrv_acc;
			qdrv_d <= qdrv_x;
		end
	end

	// DAC port registers
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			dac_qdrv <= '0;
			dac_rdrv <= '0;
		end else begin
			dac_qdrv <= qdrv_d;
			dac_rdrv <= rdrv_sum;
		end
	end

endmodule

`default_nettype wire

/* dsp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module dsp_top (
	input wire dspif,
	input wire arst_n,
	input wire dsp_pkg::sample_t adc,
	input wire dsp_pkg::sample_t amp,
	input wire dsp_pkg::freq_addr_t qdrv_freq_sel,
	input wire dsp_pkg::freq_addr_t rdrv_freq_sel [`RDRV_ELEMS],
	input wire acq_restart,
	input wire dsp_pkg::iq_word_u qdrv_freq_data,
	input wire dsp_pkg::iq_word_u qdrv_env_data,
	input wire dsp_pkg::iq_word_u rdrv_freq_data [`RDRV_ELEMS],
	input wire dsp_pkg::iq_word_u rdrv_env_data [`RDRV_ELEMS],
	output dsp_pkg::env_addr_t env_addr,
	output dsp_pkg::freq_addr_t qdrv_freq_addr,
	output dsp_pkg::freq_addr_t rdrv_freq_addr [`RDRV_ELEMS],
	output dsp_pkg::acq_addr_t acq_addr,
	output logic acq_we,
	output dsp_pkg::iq_word_u acq_data,
	output dsp_pkg::sample_t dac_qdrv,
	output dsp_pkg::sample_t dac_rdrv
);
	import dsp_pkg::*;

	sample_t qdrv_x;
	sample_t rdrv_x [`RDRV_ELEMS];

	table_addr_gen i_addr_gen (
		.dspif(dspif),
		.arst_n(arst_n),
		.qdrv_freq_sel(qdrv_freq_sel),
		.rdrv_freq_sel(rdrv_freq_sel),
		.env_addr(env_addr),
		.qdrv_freq_addr(qdrv_freq_addr),
		.rdrv_freq_addr(rdrv_freq_addr)
	);

	// element 0 is the qubit drive, the rest are readout drives
	for (genvar g = 0; g <= `RDRV_ELEMS; g++) begin : g_elem
		if (g == 0) begin : g_qdrv
			element_calc i_elem (
				.dspif(dspif),
				.arst_n(arst_n),
				.freq(qdrv_freq_data),
				.env(qdrv_env_data),
				.amp(amp),
				.x(qdrv_x),
				.y()
			);
		end else begin : g_rdrv
			element_calc i_elem (
				.dspif(dspif),
				.arst_n(arst_n),
				.freq(rdrv_freq_data[g-1]),
				.env(rdrv_env_data[g-1]),
				.amp(amp),
				.x(rdrv_x[g-1]),
				.y()
			);
		end
	end

	dac_combiner i_combiner (
		.dspif(dspif),
		.arst_n(arst_n),
		.qdrv_x(qdrv_x),
		.rdrv_x(rdrv_x),
		.dac_qdrv(dac_qdrv),
		.dac_rdrv(dac_rdrv)
	);

	acq_capture i_acq (
		.dspif(dspif),
		.arst_n(arst_n),
		.acq_restart(acq_restart),
		.adc(adc),
		.loopback(dac_qdrv), // qdrv DAC looped back into the buffer
		.acq_addr(acq_addr),
		.acq_we(acq_we),
		.acq_data(acq_data)
	);

endmodule

`default_nettype wire

/* tb_dsp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defines.svh"

module tb_dsp;
	import dsp_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int FIELDS = 15; // hex words per trace record
	localparam int MAX_RECS = 64;
	localparam int MIN_RECS = 19;
	localparam int MAX_STEPS = 256;
	localparam int PRE = 8; // history slots before reset release
	localparam int DRAIN = 6;

	logic dspif;
	logic arst_n;
	sample_t adc;
	sample_t amp;
	freq_addr_t qdrv_freq_sel;
	freq_addr_t rdrv_freq_sel [`RDRV_ELEMS];
	logic acq_restart;
	iq_word_u qdrv_freq_data;
	iq_word_u qdrv_env_data;
	iq_word_u rdrv_freq_data [`RDRV_ELEMS];
	iq_word_u rdrv_env_data [`RDRV_ELEMS];
	env_addr_t env_addr;
	freq_addr_t qdrv_freq_addr;
	freq_addr_t rdrv_freq_addr [`RDRV_ELEMS];
	acq_addr_t acq_addr;
	logic acq_we;
	iq_word_u acq_data;
	sample_t dac_qdrv;
	sample_t dac_rdrv;

	logic [31:0] trace_mem [0:MAX_RECS*FIELDS-1];
	int n_recs;
	int total_steps;
	int step;
	int cycles = 0;
	int cycle_limit = 0;
	integer seed;
	int sample_errs = 0;
	int word_errs = 0;
	int addr_errs = 0;
	int flag_errs = 0;

	// what was driven at each step, plus the expected DAC results of that step
	sample_t adc_h [0:MAX_STEPS+PRE-1];
	freq_addr_t qsel_h [0:MAX_STEPS+PRE-1];
	freq_addr_t rsel_h [0:MAX_STEPS+PRE-1][`RDRV_ELEMS];
	logic rst_h [0:MAX_STEPS+PRE-1];
	sample_t expq_h [0:MAX_STEPS+PRE-1];
	sample_t expr_h [0:MAX_STEPS+PRE-1];

	acq_addr_t m_addr; // acquisition reference state
	logic m_we;

	dsp_top i_dut (
		.dspif(dspif),
		.arst_n(arst_n),
		.adc(adc),
		.amp(amp),
		.qdrv_freq_sel(qdrv_freq_sel),
		.rdrv_freq_sel(rdrv_freq_sel),
		.acq_restart(acq_restart),
		.qdrv_freq_data(qdrv_freq_data),
		.qdrv_env_data(qdrv_env_data),
		.rdrv_freq_data(rdrv_freq_data),
		.rdrv_env_data(rdrv_env_data),
		.env_addr(env_addr),
		.qdrv_freq_addr(qdrv_freq_addr),
		.rdrv_freq_addr(rdrv_freq_addr),
		.acq_addr(acq_addr),
		.acq_we(acq_we),
		.acq_data(acq_data),
		.dac_qdrv(dac_qdrv),
		.dac_rdrv(dac_rdrv)
	);

	initial dspif = 1'b0;
	always #5 dspif = ~dspif;

	always @(posedge dspif) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout, the run went past %0d clock cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			sample_errs++;
			$display("ERROR %0t: step %0d, %s is %h, expected %h", $time, step, what, got, exp);
		end
	endtask

	task automatic check_word(input iq_word_u got, input iq_word_u exp, input string what);
		if (got.raw !== exp.raw) begin
			word_errs++;
			$display("ERROR %0t: step %0d, %s is re %h im %h, expected re %h im %h", $time,
				step, what, got.iq.re, got.iq.im, exp.iq.re, exp.iq.im);
		end
	endtask

	task automatic check_env_addr(input env_addr_t got, input env_addr_t exp, input string what);
		if (got !== exp) begin
			addr_errs++;
			$display("ERROR %0t: step %0d, %s is %h, expected %h", $time, step, what, got, exp);
		end
	endtask

	task automatic check_freq_addr(input freq_addr_t got, input freq_addr_t exp,
		input string what);
		if (got !== exp) begin
			addr_errs++;
			$display("ERROR %0t: step %0d, %s is %h, expected %h", $time, step, what, got, exp);
		end
	endtask

	task automatic check_acq_addr(input acq_addr_t got, input acq_addr_t exp, input string what);
		if (got !== exp) begin
			addr_errs++;
			$display("ERROR %0t: step %0d, %s is %h, expected %h", $time, step, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flag_errs++;
			$display("ERROR %0t: step %0d, %s is %b, expected %b", $time, step, what, got, exp);
		end
	endtask

	function automatic int record_gap(input int rec);
		return int'(trace_mem[rec*FIELDS]);
	endfunction

	task automatic load_trace(output bit ok);
		int fd;
		ok = 1'b0;
		if (`RDRV_ELEMS != 2) begin
			$display("the trace format holds exactly two readout-drive elements");
			return;
		end
		fd = $fopen("dsp_trace.txt", "r");
		if (fd == 0) begin
			$display("the trace file dsp_trace.txt could not be opened");
			return;
		end
		$fclose(fd);
		for (int i = 0; i < MAX_RECS*FIELDS; i++) begin
			trace_mem[i] = 'x;
		end
		$readmemh("dsp_trace.txt", trace_mem);
		n_recs = 0;
		while (n_recs < MAX_RECS && !$isunknown(trace_mem[n_recs*FIELDS])) begin
			n_recs++;
		end
		if (n_recs < MIN_RECS || $isunknown(trace_mem[n_recs*FIELDS-1])) begin
			$display("the trace file is short, it has %0d usable records of %0d", n_recs,
				MIN_RECS);
			return;
		end
		total_steps = DRAIN;
		for (int r = 0; r < n_recs; r++) begin
			total_steps += 1 + record_gap(r);
		end
		if (total_steps + 1 > MAX_STEPS) begin
			$display("the trace runs for %0d steps, more than the testbench can hold",
				total_steps);
			return;
		end
		ok = 1'b1;
	endtask

	task automatic record_step(input sample_t exp_q, input sample_t exp_r);
		int h;
		h = PRE + step;
		adc_h[h] = adc;
		qsel_h[h] = qdrv_freq_sel;
		for (int i = 0; i < `RDRV_ELEMS; i++) begin
			rsel_h[h][i] = rdrv_freq_sel[i];
		end
		rst_h[h] = acq_restart;
		expq_h[h] = exp_q;
		expr_h[h] = exp_r;
	endtask

	task automatic drive_line(input int rec);
		int b;
		b = rec * FIELDS;
		adc = trace_mem[b+1][`SAMPLE_W-1:0];
		amp = trace_mem[b+2][`SAMPLE_W-1:0];
		qdrv_freq_sel = trace_mem[b+3][`FREQ_AW-1:0];
		rdrv_freq_sel[0] = trace_mem[b+4][`FREQ_AW-1:0];
		rdrv_freq_sel[1] = trace_mem[b+5][`FREQ_AW-1:0];
		acq_restart = trace_mem[b+6][0];
		qdrv_freq_data.raw = trace_mem[b+7];
		qdrv_env_data.raw = trace_mem[b+8];
		rdrv_freq_data[0].raw = trace_mem[b+9];
		rdrv_env_data[0].raw = trace_mem[b+10];
		rdrv_freq_data[1].raw = trace_mem[b+11];
		rdrv_env_data[1].raw = trace_mem[b+12];
		record_step(trace_mem[b+13][`SAMPLE_W-1:0], trace_mem[b+14][`SAMPLE_W-1:0]);
	endtask

	// zero table data gives zero results, selects and amp hold
	task automatic drive_idle();
		adc = sample_t'($random(seed));
		acq_restart = 1'b0;
		qdrv_freq_data.raw = '0;
		qdrv_env_data.raw = '0;
		for (int i = 0; i < `RDRV_ELEMS; i++) begin
			rdrv_freq_data[i].raw = '0;
			rdrv_env_data[i].raw = '0;
		end
		record_step('0, '0);
	endtask

	task automatic advance();
		@(posedge dspif);
		#1;
		step++;
	endtask

	// restart seen at an edge clears the address two edges later
	task automatic step_acq_model();
		if (rst_h[PRE+step-3]) begin
			m_addr = '0;
			m_we = 1'b1;
		end else if (m_we) begin
			if (m_addr == '1) begin
				m_we = 1'b0;
			end else begin
				m_addr = m_addr + 1'b1;
			end
		end
	endtask

	task automatic check_step();
		int h;
		iq_word_u exp_word;
		h = PRE + step;
		if (step > 0) begin
			step_acq_model();
		end
		check_env_addr(env_addr, env_addr_t'(step), "env_addr");
		check_sample(dac_qdrv, expq_h[h-5], "dac_qdrv");
		check_sample(dac_rdrv, expr_h[h-5], "dac_rdrv");
		check_freq_addr(qdrv_freq_addr, qsel_h[h-2], "qdrv_freq_addr");
		for (int i = 0; i < `RDRV_ELEMS; i++) begin
			check_freq_addr(rdrv_freq_addr[i], rsel_h[h-2][i], $sformatf("rdrv_freq_addr[%0d]", i));
		end
		check_acq_addr(acq_addr, m_addr, "acq_addr");
		check_flag(acq_we, m_we, "acq_we");
		if (m_we) begin
			exp_word.iq.re = adc_h[h-2];
			exp_word.iq.im = expq_h[h-6]; // dac_qdrv one step back
			check_word(acq_data, exp_word, "acq_data");
		end
	endtask

	initial begin
		bit ok;
		seed = 29199;
		arst_n = 1'b0;
		adc = '0;
		// datapath inputs busy while in reset, outputs must still read 0
		amp = 16'h4000;
		qdrv_freq_sel = '1;
		acq_restart = 1'b0;
		qdrv_freq_data.raw = 32'h4000_0000;
		qdrv_env_data.raw = 32'h4000_0000;
		for (int i = 0; i < `RDRV_ELEMS; i++) begin
			rdrv_freq_sel[i] = '1;
			rdrv_freq_data[i].raw = 32'h4000_0000;
			rdrv_env_data[i].raw = 32'h4000_0000;
		end
		step = 0;
		m_addr = '0;
		m_we = 1'b0;
		for (int i = 0; i < MAX_STEPS + PRE; i++) begin
			adc_h[i] = '0;
			qsel_h[i] = '0;
			rsel_h[i][0] = '0;
			rsel_h[i][1] = '0;
			rst_h[i] = 1'b0;
			expq_h[i] = '0;
			expr_h[i] = '0;
		end
		load_trace(ok);
		if (!ok) begin
			$display("Test FAILED");
			$finish;
		end
		cycle_limit = RESET_CYCLES + total_steps + 20;
		repeat (RESET_CYCLES) @(posedge dspif);
		#1;
		arst_n = 1'b1;
		for (int r = 0; r < n_recs; r++) begin
			check_step();
			drive_line(r);
			advance();
			for (int g = 0; g < record_gap(r); g++) begin
				check_step();
				drive_idle();
				advance();
			end
		end
		repeat (DRAIN) begin // flush the pipeline
			check_step();
			drive_idle();
			advance();
		end
		check_step();
		$display("errors: %0d sample, %0d word, %0d address, %0d flag", sample_errs,
			word_errs, addr_errs, flag_errs);
		if (sample_errs + word_errs + addr_errs + flag_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dsp_trace.txt */
// gap adc amp qsel r0sel r1sel restart qfreq qenv r0freq r0env r1freq r1env exp_qdrv exp_rdrv
// gap is the number of idle cycles after the line, exp_* is the result of this line's inputs

// unit, negative and quadrature vectors at half amplitude
0 0100 4000 1 2 3 0 40000000 40000000 40000000 40000000 40000000 20000000 1000 1800
0 0101 4000 1 2 3 1 80000000 40000000 00004000 00004000 40000000 40000000 E000 0000
0 0102 4000 4 5 6 0 00004000 00004000 80000000 80000000 80000000 80000000 F000 8000
0 0103 4000 4 5 6 0 80000000 80000000 00004000 40000000 40000000 20000000 C000 0800

// near full scale, readout sum overflows both ways
0 0104 7FFF 7 8 9 0 7FFF0000 40000000 7FFF0000 7FFF0000 7FFF0000 7FFF0000 3FFE FFFA
0 0105 7FFF 7 8 9 0 7FFF0000 C0000000 7FFF0000 80000000 7FFF0000 80000000 C000 0002
0 0106 7FFF A B C 0 40004000 40002000 7FFF0000 40000000 7FFF0000 C0000000 0FFF FFFE
0 0107 7FFF A B C 0 7FFF0000 80000000 40004000 40002000 40004000 40002000 8001 1FFE

// negative and zero amplitude
0 0108 8000 F 0 E 0 40000000 40000000 40000000 40000000 00000000 00000000 E000 E000
3 0109 0000 F 0 E 0 7FFF0000 7FFF0000 7FFF0000 7FFF0000 7FFF0000 7FFF0000 0000 0000

// long gap lets the first fill reach all-ones and lock
0 010A 4000 2 2 2 0 00004000 40000000 80000000 40000000 80000000 40000000 0000 C000
3C 010B 4000 2 2 2 0 40000000 20000000 40000000 20000000 00004000 00004000 0800 F800

// second restart fills from 0 again
0 0200 4000 3 3 3 1 40000000 40000000 00000000 00000000 00000000 00000000 1000 0000
0 0201 4000 3 3 3 0 80000000 80000000 40000000 40000000 40000000 40000000 C000 2000
0 0202 7FFF 5 6 7 0 7FFF0000 7FFF0000 7FFF0000 C0000000 7FFF0000 C0000000 7FFD 8000
0 0203 7FFF 5 6 7 0 7FFF0000 40000000 7FFF0000 7FFF0000 40004000 40002000 3FFE 8FFC
8 0204 4000 5 6 7 0 00004000 00004000 80000000 80000000 40000000 40000000 F000 D000

// tail
0 0205 7FFF 0 0 0 0 7FFF0000 C0000000 7FFF0000 80000000 7FFF0000 40000000 C000 BFFF
4 0206 8000 0 0 0 0 40000000 40000000 40000000 40000000 40000000 40000000 E000 C000

/* tb.f */
+incdir+.
dsp_pkg.sv
table_addr_gen.sv
acq_capture.sv
element_calc.sv
dac_combiner.sv
dsp_top.sv
tb_dsp.sv

/* Bender.yml */
package:
  name: qubit_dsp

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dsp_pkg.sv
      - table_addr_gen.sv
      - acq_capture.sv
      - element_calc.sv
      - dac_combiner.sv
      - dsp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dsp.sv
